//--- hw/rs485_line_pkg.sv
package rs485_line_pkg;

  // ------------------------------------------------------------
  // Quarter-bit timing, clock cycles per quarter
  // ------------------------------------------------------------
  localparam int QDIV_FAST = 8;   // 1 MHz bit rate from 32 MHz
  localparam int QDIV_SLOW = 32;
  localparam int QCNT_W    = $clog2(QDIV_SLOW);  // Divider counter width

  // Transceiver direction
  localparam logic DIR_RX = 1'b0;
  localparam logic DIR_TX = 1'b1;

  // Line engine states
  typedef enum logic [3:0] {
    TX_WAIT,
    TX_FIRST,   // Marker + first byte
    TX_NEXT,
    TX_DONE,    // Idle quarters before turnaround
    RX_WAIT,
    RX_FIRST,
    RX_NEXT,
    RX_DONE,
    RX_DONE2
  } engine_state_t;

  // One receive FIFO entry
  typedef struct packed {
    logic       first;  // First byte of a reply
    logic [7:0] data;
  } rx_entry_t;

endpackage

//--- hw/rs485_regs_pkg.sv
package rs485_regs_pkg;

  // Register map
  localparam logic [7:0] ADDR_CTRL   = 8'h00;
  localparam logic [7:0] ADDR_STATUS = 8'h04;  // Read only
  localparam logic [7:0] ADDR_TXDATA = 8'h08;  // Write only
  localparam logic [7:0] ADDR_RXDATA = 8'h0C;  // Read pops the RX FIFO

  // CTRL bits
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_SLOW_BIT  = 1;

  // Result codes reported by the engine
  localparam logic [2:0] STAT_NONE   = 3'd0;
  localparam logic [2:0] STAT_RX_OK  = 3'd1;
  localparam logic [2:0] STAT_RX_ERR = 3'd2;

  // STATUS bits, result sits in 2:0
  localparam int STAT_BUSY_BIT    = 4;
  localparam int STAT_TXFULL_BIT  = 5;
  localparam int STAT_RXEMPTY_BIT = 6;

  // RXDATA layout, data in 7:0
  localparam int RXD_FIRST_BIT = 8;
  localparam int RXD_EMPTY_BIT = 31;

  localparam int FIFO_DEPTH = 16;

endpackage

//--- hw/rs485_fifo.sv
`timescale 1ns/1ps

module rs485_fifo #(
  parameter type entry_t = logic [7:0]
) (
  input  logic   p_in_clk,
  input  logic   p_in_rst,
  input  logic   i_wr,
  input  entry_t i_wdata,
  input  logic   i_rd,
  output entry_t o_rdata,
  output logic   o_empty,
  output logic   o_full
);

  logic [$clog2(rs485_regs_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(rs485_regs_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(rs485_regs_pkg::FIFO_DEPTH):0]   count;
  logic do_wr;
  logic do_rd;

  entry_t mem [rs485_regs_pkg::FIFO_DEPTH];

  assign o_empty = (count == '0);
  assign o_full  = (count == ($clog2(rs485_regs_pkg::FIFO_DEPTH) + 1)'(rs485_regs_pkg::FIFO_DEPTH));

  assign do_wr = i_wr && !o_full;   // Overflow is dropped
  assign do_rd = i_rd && !o_empty;

  assign o_rdata = mem[rd_ptr];     // Head visible without a read strobe

  // Storage
  always_ff @(posedge p_in_clk) begin
    if (do_wr)
      mem[wr_ptr] <= i_wdata;
  end

  // Pointers and fill level
  always_ff @(posedge p_in_clk) begin
    if (p_in_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/rs485_bit_timer.sv
`timescale 1ns/1ps

module rs485_bit_timer (
  input  logic p_in_clk,
  input  logic p_in_rst,
  input  logic i_phy_rx,
  input  logic i_dir,
  input  logic i_slow,
  input  logic i_div_clr,
  output logic o_rx_sync,
  output logic o_rx_start,
  output logic o_qtr_en
);

  logic [1:0] sync_q;   // Two-flop synchronizer
  logic       rx_prev;
  logic       rx_edge;
  logic       rx_fall;
  logic       resync;
  logic [rs485_line_pkg::QCNT_W-1:0] cnt;
  logic [rs485_line_pkg::QCNT_W-1:0] qdiv_last;
  logic [rs485_line_pkg::QCNT_W-1:0] qdiv_mid;

  assign o_rx_sync = sync_q[1];
  assign rx_edge   = rx_prev ^ sync_q[1];
  assign rx_fall   = rx_prev & ~sync_q[1];

  assign qdiv_last = i_slow ? rs485_line_pkg::QCNT_W'(rs485_line_pkg::QDIV_SLOW - 1)
                            : rs485_line_pkg::QCNT_W'(rs485_line_pkg::QDIV_FAST - 1);
  assign qdiv_mid  = i_slow ? rs485_line_pkg::QCNT_W'(rs485_line_pkg::QDIV_SLOW / 2)
                            : rs485_line_pkg::QCNT_W'(rs485_line_pkg::QDIV_FAST / 2);

  // Receive: restart on each edge so the pulse lands mid-quarter
  assign resync = (i_dir == rs485_line_pkg::DIR_RX) && (rx_edge || !o_rx_start);

  // ------------------------------------------------------------
  // Line input and start detection
  // ------------------------------------------------------------
  always_ff @(posedge p_in_clk) begin
    if (p_in_rst) begin
      sync_q     <= 2'b11;  // Idle line is high
      rx_prev    <= 1'b1;
      o_rx_start <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], i_phy_rx};
      rx_prev <= sync_q[1];
      if (i_dir == rs485_line_pkg::DIR_TX)
        o_rx_start <= 1'b0;
      else if (rx_fall)
        o_rx_start <= 1'b1;  // Marker falling edge
    end
  end

  // ------------------------------------------------------------
  // Quarter-bit divider
  // ------------------------------------------------------------
  always_ff @(posedge p_in_clk) begin
    if (p_in_rst) begin
      cnt      <= '0;
      o_qtr_en <= 1'b0;
    end else begin
      if (i_div_clr || resync)
        cnt <= '0;
      else if (cnt >= qdiv_last)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
      o_qtr_en <= !i_div_clr && (cnt == qdiv_mid);
    end
  end

endmodule

//--- hw/rs485_line_engine.sv
`timescale 1ns/1ps

module rs485_line_engine (
  input  logic                      p_in_clk,
  input  logic                      p_in_rst,
  input  logic                      i_qtr_en,
  input  logic                      i_rx_sync,
  input  logic                      i_rx_start,
  input  logic                      i_txd_rdy,
  input  logic [7:0]                i_txd,
  output logic                      o_div_clr,
  output logic                      o_txd_rd,
  output logic                      o_phy_tx,
  output logic                      o_phy_dir,
  output logic                      o_rxd_wr,
  output rs485_line_pkg::rx_entry_t o_rxd,
  output logic [2:0]                o_status,
  output logic                      o_busy
);

  rs485_line_pkg::engine_state_t state;

  logic [5:0] qcnt;      // Quarter index within marker + byte
  logic [5:0] pos;       // Quarter index within the byte itself
  logic       tx_act;
  logic       rx_act;
  logic       tx_par;
  logic       tx_bit;
  logic       tx_line;
  logic [7:0] rx_byte;
  logic [1:0] stop_chk;
  logic       rx_err;

  assign o_busy = (state != rs485_line_pkg::TX_WAIT);
  assign tx_act = state inside {rs485_line_pkg::TX_FIRST, rs485_line_pkg::TX_NEXT};
  assign rx_act = state inside {rs485_line_pkg::RX_FIRST, rs485_line_pkg::RX_NEXT};

  // ------------------------------------------------------------
  // Quarter position and Manchester encoding
  // ------------------------------------------------------------
  always_comb begin
    case (state)
      rs485_line_pkg::TX_FIRST: pos = qcnt - 6'd4;  // Skip 4 marker quarters
      rs485_line_pkg::RX_FIRST: pos = qcnt - 6'd1;  // Last marker quarter left
      default:                  pos = qcnt;
    endcase
    tx_bit = i_txd[3'd7 - pos[4:2]];  // MSB first
    if (state == rs485_line_pkg::TX_FIRST && qcnt < 6'd4)
      tx_line = ~qcnt[1];             // Marker, high then low
    else if (pos < 6'd32)
      tx_line = pos[1] ? tx_bit : ~tx_bit;
    else
      tx_line = pos[1] ? tx_par : ~tx_par;
  end

  // Payload registers
  always_ff @(posedge p_in_clk) begin
    if (i_qtr_en) begin
      if (tx_act && pos == 6'd31)
        tx_par <= ^i_txd;
      if (rx_act && pos < 6'd32 && pos[1:0] == 2'd3)
        rx_byte[3'd7 - pos[4:2]] <= i_rx_sync;  // True half of the bit
      if (rx_act && pos == 6'd35) begin
        o_rxd.first <= (state == rs485_line_pkg::RX_FIRST);
        o_rxd.data  <= rx_byte;
      end
    end
  end

  // ------------------------------------------------------------
  // Main FSM
  // ------------------------------------------------------------
  always_ff @(posedge p_in_clk) begin
    if (p_in_rst) begin
      state     <= rs485_line_pkg::TX_WAIT;
      qcnt      <= '0;
      stop_chk  <= '0;
      rx_err    <= 1'b0;
      o_div_clr <= 1'b0;
      o_txd_rd  <= 1'b0;
      o_rxd_wr  <= 1'b0;
      o_phy_tx  <= 1'b1;
      o_phy_dir <= rs485_line_pkg::DIR_RX;
      o_status  <= rs485_regs_pkg::STAT_NONE;
    end else begin
      o_div_clr <= 1'b0;  // Strobes last one clock
      o_txd_rd  <= 1'b0;
      o_rxd_wr  <= 1'b0;

      case (state)
        rs485_line_pkg::TX_WAIT: begin
          if (i_txd_rdy) begin
            o_status  <= rs485_regs_pkg::STAT_NONE;
            o_phy_dir <= rs485_line_pkg::DIR_TX;
            qcnt      <= '0;
            state     <= rs485_line_pkg::TX_FIRST;
          end
        end

        rs485_line_pkg::TX_FIRST, rs485_line_pkg::TX_NEXT: begin
          if (i_qtr_en) begin
            o_phy_tx <= tx_line;
            if (pos == 6'd33)
              o_txd_rd <= 1'b1;  // Byte and parity captured, pop it
            if (pos == 6'd35) begin
              qcnt  <= '0;
              state <= i_txd_rdy ? rs485_line_pkg::TX_NEXT : rs485_line_pkg::TX_DONE;
            end else begin
              qcnt <= qcnt + 1'b1;
            end
          end
        end

        rs485_line_pkg::TX_DONE: begin
          if (i_qtr_en) begin
            o_phy_tx <= 1'b1;
            if (qcnt == 6'd3) begin
              qcnt      <= '0;
              o_phy_dir <= rs485_line_pkg::DIR_RX;
              o_div_clr <= 1'b1;
              state     <= rs485_line_pkg::RX_WAIT;
            end else begin
              qcnt <= qcnt + 1'b1;
            end
          end
        end

        rs485_line_pkg::RX_WAIT: begin
          if (i_rx_start) begin
            if (i_qtr_en) begin   // Middle of first low marker quarter
              qcnt  <= '0;
              state <= rs485_line_pkg::RX_FIRST;
            end
          end else if (i_txd_rdy) begin
            state <= rs485_line_pkg::TX_WAIT;  // New request before any reply
          end
        end

        rs485_line_pkg::RX_FIRST, rs485_line_pkg::RX_NEXT: begin
          if (i_qtr_en) begin
            if (state == rs485_line_pkg::RX_NEXT && pos < 6'd2)
              stop_chk[pos[0]] <= i_rx_sync;
            if (state == rs485_line_pkg::RX_NEXT && pos == 6'd2 && (&stop_chk) && i_rx_sync) begin
              state <= rs485_line_pkg::RX_DONE;  // Idle at byte boundary
            end else if (pos == 6'd35) begin
              qcnt <= '0;
              if ((^rx_byte) != i_rx_sync) begin
                rx_err <= 1'b1;
                state  <= rs485_line_pkg::RX_DONE;
              end else begin
                o_rxd_wr <= 1'b1;
                state    <= rs485_line_pkg::RX_NEXT;
              end
            end else begin
              qcnt <= qcnt + 1'b1;
            end
          end
        end

        rs485_line_pkg::RX_DONE: begin
          if (i_qtr_en) begin
            o_status <= rx_err ? rs485_regs_pkg::STAT_RX_ERR : rs485_regs_pkg::STAT_RX_OK;
            rx_err   <= 1'b0;
            state    <= rs485_line_pkg::RX_DONE2;
          end
        end

        rs485_line_pkg::RX_DONE2: begin
          if (i_qtr_en) begin
            o_div_clr <= 1'b1;
            state     <= rs485_line_pkg::TX_WAIT;
          end
        end

        default: state <= rs485_line_pkg::TX_WAIT;
      endcase
    end
  end

endmodule

//--- hw/rs485_apb_regs.sv
`timescale 1ns/1ps

module rs485_apb_regs (
  input  logic                      p_in_clk,
  input  logic                      p_in_rst,
  // APB
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic                      i_pwrite,
  input  logic [7:0]                i_paddr,
  input  logic [31:0]               i_pwdata,
  output logic [31:0]               o_prdata,
  output logic                      o_pready,
  output logic                      o_pslverr,
  // FIFOs
  output logic                      o_tx_wr,
  output logic [7:0]                o_tx_wdata,
  output logic                      o_rx_rd,
  input  logic                      i_tx_full,
  input  logic                      i_tx_empty,
  input  logic                      i_rx_empty,
  input  rs485_line_pkg::rx_entry_t i_rx_rdata,
  // Engine
  input  logic                      i_txd_rd,
  input  logic [2:0]                i_status,
  input  logic                      i_busy,
  output logic                      o_txd_rdy,
  output logic                      o_slow
);

  logic access;
  logic start;
  logic txd_rd_q;

  assign access   = i_psel && i_penable;
  assign o_pready = 1'b1;  // Zero wait states

  assign o_tx_wr    = access && i_pwrite && (i_paddr == rs485_regs_pkg::ADDR_TXDATA) && !i_tx_full;
  assign o_tx_wdata = i_pwdata[7:0];
  assign o_rx_rd    = access && !i_pwrite && (i_paddr == rs485_regs_pkg::ADDR_RXDATA) && !i_rx_empty;

  assign o_txd_rdy = start && !i_tx_empty;

  // ------------------------------------------------------------
  // Read data and error response
  // ------------------------------------------------------------
  always_comb begin
    o_prdata  = '0;
    o_pslverr = 1'b0;
    case (i_paddr)
      rs485_regs_pkg::ADDR_CTRL: begin
        o_prdata[rs485_regs_pkg::CTRL_START_BIT] = start;
        o_prdata[rs485_regs_pkg::CTRL_SLOW_BIT]  = o_slow;
      end
      rs485_regs_pkg::ADDR_STATUS: begin
        o_prdata[2:0]                              = i_status;
        o_prdata[rs485_regs_pkg::STAT_BUSY_BIT]    = i_busy;
        o_prdata[rs485_regs_pkg::STAT_TXFULL_BIT]  = i_tx_full;
        o_prdata[rs485_regs_pkg::STAT_RXEMPTY_BIT] = i_rx_empty;
        o_pslverr = access && i_pwrite;          // Read only
      end
      rs485_regs_pkg::ADDR_TXDATA: begin
        o_pslverr = access && (!i_pwrite || i_tx_full);
      end
      rs485_regs_pkg::ADDR_RXDATA: begin
        o_prdata[7:0]                            = i_rx_rdata.data;
        o_prdata[rs485_regs_pkg::RXD_FIRST_BIT]  = i_rx_rdata.first;
        o_prdata[rs485_regs_pkg::RXD_EMPTY_BIT]  = i_rx_empty;
      end
      default: o_pslverr = access;  // Unmapped
    endcase
  end

  // ------------------------------------------------------------
  // Control bits
  // ------------------------------------------------------------
  always_ff @(posedge p_in_clk) begin
    if (p_in_rst) begin
      start    <= 1'b0;
      o_slow   <= 1'b0;
      txd_rd_q <= 1'b0;
    end else begin
      txd_rd_q <= i_txd_rd;  // Empty flag is valid one clock after the pop
      if (access && i_pwrite && (i_paddr == rs485_regs_pkg::ADDR_CTRL)) begin
        start  <= i_pwdata[rs485_regs_pkg::CTRL_START_BIT];
        o_slow <= i_pwdata[rs485_regs_pkg::CTRL_SLOW_BIT];
      end else if (txd_rd_q && i_tx_empty) begin
        start <= 1'b0;       // Last byte taken
      end
    end
  end

endmodule

//--- hw/rs485_master_top.sv
`timescale 1ns/1ps

module rs485_master_top (
  input  logic        p_in_clk,
  input  logic        p_in_rst,
  // APB
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [7:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  // RS-485 transceiver
  input  logic        i_phy_rx,
  output logic        o_phy_tx,
  output logic        o_phy_dir
);

  // Register block <-> FIFOs
  logic                      tx_wr;
  logic [7:0]                tx_wdata;
  logic                      tx_full;
  logic                      tx_empty;
  logic [7:0]                tx_rdata;
  logic                      rx_rd;
  logic                      rx_empty;
  rs485_line_pkg::rx_entry_t rx_rdata;

  // Engine side
  logic                      txd_rdy;
  logic                      txd_rd;
  logic                      rxd_wr;
  rs485_line_pkg::rx_entry_t rxd;
  logic [2:0]                status;
  logic                      busy;
  logic                      slow;

  // Timer side
  logic rx_sync;
  logic rx_start;
  logic qtr_en;
  logic div_clr;

  rs485_apb_regs u_regs (
    .p_in_clk   (p_in_clk),
    .p_in_rst   (p_in_rst),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .o_tx_wr    (tx_wr),
    .o_tx_wdata (tx_wdata),
    .o_rx_rd    (rx_rd),
    .i_tx_full  (tx_full),
    .i_tx_empty (tx_empty),
    .i_rx_empty (rx_empty),
    .i_rx_rdata (rx_rdata),
    .i_txd_rd   (txd_rd),
    .i_status   (status),
    .i_busy     (busy),
    .o_txd_rdy  (txd_rdy),
    .o_slow     (slow)
  );

  rs485_fifo #(.entry_t(logic [7:0])) u_tx_fifo (
    .p_in_clk (p_in_clk),
    .p_in_rst (p_in_rst),
    .i_wr     (tx_wr),
    .i_wdata  (tx_wdata),
    .i_rd     (txd_rd),
    .o_rdata  (tx_rdata),
    .o_empty  (tx_empty),
    .o_full   (tx_full)
  );

  // Pushes into a full RX FIFO are dropped inside the FIFO
  rs485_fifo #(.entry_t(rs485_line_pkg::rx_entry_t)) u_rx_fifo (
    .p_in_clk (p_in_clk),
    .p_in_rst (p_in_rst),
    .i_wr     (rxd_wr),
    .i_wdata  (rxd),
    .i_rd     (rx_rd),
    .o_rdata  (rx_rdata),
    .o_empty  (rx_empty),
    .o_full   ()
  );

  rs485_bit_timer u_timer (
    .p_in_clk   (p_in_clk),
    .p_in_rst   (p_in_rst),
    .i_phy_rx   (i_phy_rx),
    .i_dir      (o_phy_dir),
    .i_slow     (slow),
    .i_div_clr  (div_clr),
    .o_rx_sync  (rx_sync),
    .o_rx_start (rx_start),
    .o_qtr_en   (qtr_en)
  );

  rs485_line_engine u_engine (
    .p_in_clk   (p_in_clk),
    .p_in_rst   (p_in_rst),
    .i_qtr_en   (qtr_en),
    .i_rx_sync  (rx_sync),
    .i_rx_start (rx_start),
    .i_txd_rdy  (txd_rdy),
    .i_txd      (tx_rdata),
    .o_div_clr  (div_clr),
    .o_txd_rd   (txd_rd),
    .o_phy_tx   (o_phy_tx),
    .o_phy_dir  (o_phy_dir),
    .o_rxd_wr   (rxd_wr),
    .o_rxd      (rxd),
    .o_status   (status),
    .o_busy     (busy)
  );

endmodule

//--- sim/rs485_slave_model.sv
`timescale 1ns/1ps

module rs485_slave_model (
  input  logic p_in_clk,
  input  logic i_phy_tx,
  input  logic i_phy_dir,
  output logic o_phy_rx
);

  // Loaded by the testbench before each request
  logic [7:0] reply_q[$];
  int         corrupt_idx;   // Reply byte with flipped parity, -1 for none

  // Results of the last decoded request
  logic [7:0] rx_q[$];
  int         qdiv_meas;
  int         parity_errs;
  int         coding_errs;
  logic       reply_done;

  int   runs[$];   // Run lengths in clocks
  logic lvls[$];
  logic qtrs[$];

  function automatic int gcd(input int a, input int b);
    int t;
    while (b != 0) begin
      t = a % b;
      a = b;
      b = t;
    end
    return a;
  endfunction

  // ------------------------------------------------------------
  // Frame capture, starts at the marker falling edge
  // ------------------------------------------------------------
  task automatic capture_frame();
    logic started;
    logic lvl;
    int   len;
    runs.delete();
    lvls.delete();
    started = 1'b0;
    lvl     = 1'b1;
    len     = 0;
    while (1) begin
      @(negedge p_in_clk);
      if (i_phy_dir != rs485_line_pkg::DIR_TX)
        break;
      if (!started) begin
        if (!i_phy_tx) begin
          started = 1'b1;
          lvl     = 1'b0;
          len     = 1;
        end
      end else if (i_phy_tx == lvl) begin
        len++;
      end else begin
        runs.push_back(len);
        lvls.push_back(lvl);
        lvl = i_phy_tx;
        len = 1;
      end
    end
    if (started) begin
      runs.push_back(len);   // Runs into the idle tail
      lvls.push_back(lvl);
    end
  endtask

  task automatic decode_frame();
    int         g;
    int         k;
    int         base;
    logic [7:0] b;
    logic       v;
    g = 0;
    for (int i = 0; i < runs.size() - 1; i++)
      g = gcd(g, runs[i]);
    qdiv_meas = g / 2;     // Shortest run unit is two quarters
    rx_q.delete();
    qtrs.delete();
    if (qdiv_meas == 0) begin
      coding_errs++;
      return;
    end
    foreach (runs[i])
      repeat (runs[i] / qdiv_meas) qtrs.push_back(lvls[i]);
    if (qtrs.size() < 2 || qtrs[0] || qtrs[1])
      coding_errs++;       // Low half of the marker
    for (int n = 0; 2 + 36 * (n + 1) <= qtrs.size(); n++) begin
      base = 2 + 36 * n;
      b    = '0;
      for (int j = 0; j < 9; j++) begin
        k = base + 4 * j;
        if (qtrs[k] != qtrs[k+1] || qtrs[k+2] != qtrs[k+3] || qtrs[k] == qtrs[k+2])
          coding_errs++;
        v = qtrs[k+2];     // True half
        if (j < 8)
          b[7-j] = v;
        else if (v != ^b)
          parity_errs++;
      end
      rx_q.push_back(b);
    end
  endtask

  // ------------------------------------------------------------
  // Reply generation
  // ------------------------------------------------------------
  task automatic drive_qtrs(input logic v, input int n);
    o_phy_rx = v;
    repeat (n * qdiv_meas) @(negedge p_in_clk);
  endtask

  task automatic send_reply();
    logic [7:0] b;
    logic       v;
    drive_qtrs(1'b1, 4);  // Turnaround gap
    drive_qtrs(1'b1, 2);  // Marker
    drive_qtrs(1'b0, 2);
    foreach (reply_q[i]) begin
      b = reply_q[i];
      for (int j = 0; j < 9; j++) begin
        v = (j < 8) ? b[7-j] : ^b;
        if (j == 8 && i == corrupt_idx)
          v = ~v;
        drive_qtrs(~v, 2);
        drive_qtrs(v, 2);
      end
    end
    drive_qtrs(1'b1, 8);  // Idle tail ends the reply
  endtask

  initial begin
    o_phy_rx    = 1'b1;
    reply_done  = 1'b0;
    qdiv_meas   = 0;
    parity_errs = 0;
    coding_errs = 0;
    forever begin
      wait (i_phy_dir == rs485_line_pkg::DIR_TX);
      reply_done  = 1'b0;
      parity_errs = 0;
      coding_errs = 0;
      capture_frame();
      decode_frame();
      if (qdiv_meas > 0)
        send_reply();
      reply_done = 1'b1;
    end
  end

endmodule

//--- sim/tb_rs485_master.sv
`timescale 1ns/1ps

module tb_rs485_master;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_RUNS   = 5;
  // Longest request plus reply, in quarters
  localparam int RUN_QTRS   = 40 + 36 * 16 + 8 + 40 + 36 * 4 + 16;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_QTRS * rs485_line_pkg::QDIV_SLOW + 5000;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        phy_rx;
  logic        phy_tx;
  logic        phy_dir;

  int          mismatch_errs;
  int          other_errs;
  int unsigned lcg_state;
  logic [7:0]  tx_q[$];
  logic [7:0]  reply_q[$];

  rs485_master_top dut (
    .p_in_clk  (clk),
    .p_in_rst  (rst),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .i_phy_rx  (phy_rx),
    .o_phy_tx  (phy_tx),
    .o_phy_dir (phy_dir)
  );

  rs485_slave_model u_slave (
    .p_in_clk  (clk),
    .i_phy_tx  (phy_tx),
    .i_phy_dir (phy_dir),
    .o_phy_rx  (phy_rx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Line must rest high whenever the master listens
  line_idle_in_rx: assert property (@(posedge clk) disable iff (rst)
    (phy_dir == rs485_line_pkg::DIR_RX) |-> phy_tx)
    else begin
      other_errs++;
      $display("ERROR at %0t ns: line driven low while direction is receive", $time);
    end

  initial begin
    #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
    $display("ERROR at %0t ns: watchdog expired, DUT stopped responding", $time);
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else begin
        mismatch_errs++;
        $display("MISMATCH at %0t ns: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      end
  endtask

  // ------------------------------------------------------------
  // APB access, driven on the falling edge
  // ------------------------------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_val("pready", 1, pready);   // Zero wait states
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_val("pready", 1, pready);
    data = prdata;   // Sampled before the pop edge
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic fill_queues(input int n_tx, input int n_reply);
    tx_q.delete();
    reply_q.delete();
    repeat (n_tx) tx_q.push_back(rand_byte());
    repeat (n_reply) reply_q.push_back(rand_byte());
  endtask

  task automatic load_tx();
    logic err;
    foreach (tx_q[i]) begin
      apb_write(rs485_regs_pkg::ADDR_TXDATA, {24'h0, tx_q[i]}, err);
      check_val("pslverr on TXDATA write", 0, err);
    end
  endtask

  // Start a request and check the frame, the reply and the result
  task automatic run_request(input logic slow, input int corrupt, input logic [2:0] exp_stat,
                             input int n_rx);
    logic [31:0] ctrl;
    logic [31:0] rd;
    logic        err;
    int          qexp;
    u_slave.reply_q     = reply_q;
    u_slave.corrupt_idx = corrupt;
    ctrl = '0;
    ctrl[rs485_regs_pkg::CTRL_START_BIT] = 1'b1;
    ctrl[rs485_regs_pkg::CTRL_SLOW_BIT]  = slow;
    apb_write(rs485_regs_pkg::ADDR_CTRL, ctrl, err);
    wait (phy_dir == rs485_line_pkg::DIR_TX);
    do begin
      apb_read(rs485_regs_pkg::ADDR_STATUS, rd, err);
    end while (rd[rs485_regs_pkg::STAT_BUSY_BIT] || rd[2:0] == rs485_regs_pkg::STAT_NONE);
    wait (u_slave.reply_done);
    check_val("STATUS.result", exp_stat, rd[2:0]);
    qexp = slow ? rs485_line_pkg::QDIV_SLOW : rs485_line_pkg::QDIV_FAST;
    check_val("quarter period", qexp, u_slave.qdiv_meas);
    check_val("frame byte count", tx_q.size(), u_slave.rx_q.size());
    foreach (tx_q[i])
      if (i < u_slave.rx_q.size())
        check_val($sformatf("frame byte %0d", i), tx_q[i], u_slave.rx_q[i]);
    check_val("frame parity errors", 0, u_slave.parity_errs);
    check_val("frame coding errors", 0, u_slave.coding_errs);
    for (int i = 0; i < n_rx; i++) begin
      apb_read(rs485_regs_pkg::ADDR_RXDATA, rd, err);
      check_val($sformatf("RXDATA.data %0d", i), reply_q[i], rd[7:0]);
      check_val($sformatf("RXDATA.first %0d", i), (i == 0), rd[rs485_regs_pkg::RXD_FIRST_BIT]);
      check_val("RXDATA.empty", 0, rd[rs485_regs_pkg::RXD_EMPTY_BIT]);
    end
    apb_read(rs485_regs_pkg::ADDR_RXDATA, rd, err);
    check_val("RXDATA.empty after reply", 1, rd[rs485_regs_pkg::RXD_EMPTY_BIT]);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          k;
    rst           = 1'b1;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    mismatch_errs = 0;
    other_errs    = 0;
    lcg_state     = 32'd78;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Reset state
    check_val("o_phy_tx", 1, phy_tx);
    check_val("o_phy_dir", rs485_line_pkg::DIR_RX, phy_dir);
    apb_read(rs485_regs_pkg::ADDR_STATUS, rd, err);
    check_val("STATUS.result", rs485_regs_pkg::STAT_NONE, rd[2:0]);
    check_val("STATUS.busy", 0, rd[rs485_regs_pkg::STAT_BUSY_BIT]);
    apb_read(rs485_regs_pkg::ADDR_RXDATA, rd, err);
    check_val("RXDATA.empty", 1, rd[rs485_regs_pkg::RXD_EMPTY_BIT]);

    // Fast then slow rate, clean reply
    for (int r = 0; r < 2; r++) begin
      fill_queues(2 + rand_byte() % 5, 1 + rand_byte() % 4);
      load_tx();
      run_request(r[0], -1, rs485_regs_pkg::STAT_RX_OK, reply_q.size());
    end

    // Parity error in reply byte k
    fill_queues(2 + rand_byte() % 5, 4);
    k = 1 + rand_byte() % 3;
    load_tx();
    run_request(1'b0, k, rs485_regs_pkg::STAT_RX_ERR, k);

    // ------------------------------------------------------------
    // APB error responses
    // ------------------------------------------------------------
    apb_read(8'h10, rd, err);
    check_val("pslverr on unmapped read", 1, err);
    apb_write(rs485_regs_pkg::ADDR_STATUS, 32'h0, err);
    check_val("pslverr on STATUS write", 1, err);
    fill_queues(rs485_regs_pkg::FIFO_DEPTH, 1);
    load_tx();
    apb_write(rs485_regs_pkg::ADDR_TXDATA, 32'hA5, err);
    check_val("pslverr on full TXDATA write", 1, err);
    run_request(1'b0, -1, rs485_regs_pkg::STAT_RX_OK, 1);

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- tb.f
hw/rs485_line_pkg.sv
hw/rs485_regs_pkg.sv
hw/rs485_fifo.sv
hw/rs485_bit_timer.sv
hw/rs485_line_engine.sv
hw/rs485_apb_regs.sv
hw/rs485_master_top.sv
sim/rs485_slave_model.sv
sim/tb_rs485_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RS-485 master testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module tb_rs485_master -f tb.f -o tb_sim \
  && out="$(./obj_dir/tb_sim)" \
  && echo "$out" \
  && echo "$out" | grep -qx "Result: PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
